/* logic/decoder_pkg.sv */
package decoder_pkg;

  ////////////////////////////////////////
  // major opcodes and widths
  ////////////////////////////////////////

  localparam int unsigned INSN_W = 32;       // rv32 word, no compressed

  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  ////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLTS, ALU_SLTU,                      // sltu doubles as idle op
    ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU  // branch compares
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA, OP_A_CURRPC, OP_A_ZIMM, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REGB, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR, IMM_SB} imm_sel_e;

  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;
  typedef enum logic [1:0] {BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND} branch_e;

  // one fetched word, seen as R type or I type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;                    // also csr address / system func
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } insn_u;

  typedef struct packed {
    alu_op_e    alu_operator;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    logic       rega_used;
    logic       regb_used;
    logic       regfile_alu_we;              // alu / csr writeback port
    logic       regfile_mem_we;              // load writeback port
    logic       data_req;
    logic       data_we;
    data_type_e data_type;
    logic       data_sign_ext;
    logic       mult_en;
    logic       csr_access;
    csr_op_e    csr_op;
    branch_e    jump_in_id;
    branch_e    jump_target_sel;
    logic       illegal;
    logic       ecall;
    logic       trap;                        // ebreak
    logic       eret;
    logic       pipe_flush;                  // wfi
  } ctrl_t;

  localparam ctrl_t CTRL_IDLE = '{
    alu_operator:    ALU_SLTU,
    op_a_sel:        OP_A_REGA,
    op_b_sel:        OP_B_REGB,
    imm_sel:         IMM_I,
    rega_used:       1'b0,
    regb_used:       1'b0,
    regfile_alu_we:  1'b0,
    regfile_mem_we:  1'b0,
    data_req:        1'b0,
    data_we:         1'b0,
    data_type:       DT_WORD,
    data_sign_ext:   1'b0,
    mult_en:         1'b0,
    csr_access:      1'b0,
    csr_op:          CSR_NONE,
    jump_in_id:      BRANCH_NONE,
    jump_target_sel: BRANCH_NONE,
    illegal:         1'b0,
    ecall:           1'b0,
    trap:            1'b0,
    eret:            1'b0,
    pipe_flush:      1'b0
  };

endpackage

/* logic/flow_decoder.sv */
`timescale 1ns/1ns

module flow_decoder (
  input  decoder_pkg::insn_u insn_i,
  output logic               hit_o,
  output decoder_pkg::ctrl_t ctrl_o
);

  always_comb begin
    hit_o  = 1'b1;
    ctrl_o = decoder_pkg::CTRL_IDLE;

    case (insn_i.r_fmt.opcode)
      decoder_pkg::OPC_JAL, decoder_pkg::OPC_JALR: begin
        // link value pc+4 goes through the alu
        ctrl_o.op_a_sel       = decoder_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel       = decoder_pkg::OP_B_IMM;
        ctrl_o.imm_sel        = decoder_pkg::IMM_PCINCR;
        ctrl_o.alu_operator   = decoder_pkg::ALU_ADD;
        ctrl_o.regfile_alu_we = 1'b1;
        ctrl_o.jump_in_id      = decoder_pkg::BRANCH_JAL;  // target pc + uj imm
        ctrl_o.jump_target_sel = decoder_pkg::BRANCH_JAL;
        if (insn_i.r_fmt.opcode == decoder_pkg::OPC_JALR) begin
          ctrl_o.jump_in_id      = decoder_pkg::BRANCH_JALR;  // target rs1 + i imm
          ctrl_o.jump_target_sel = decoder_pkg::BRANCH_JALR;
          ctrl_o.rega_used       = 1'b1;
          if (insn_i.r_fmt.funct3 != 3'b000) begin  // reserved encoding, do nothing
            ctrl_o.jump_in_id     = decoder_pkg::BRANCH_NONE;
            ctrl_o.regfile_alu_we = 1'b0;
          end
        end
      end

      decoder_pkg::OPC_BRANCH: begin
        ctrl_o.jump_in_id      = decoder_pkg::BRANCH_COND;
        ctrl_o.jump_target_sel = decoder_pkg::BRANCH_COND;
        ctrl_o.imm_sel         = decoder_pkg::IMM_SB;  // pc relative target
        ctrl_o.rega_used       = 1'b1;
        ctrl_o.regb_used       = 1'b1;
        case (insn_i.r_fmt.funct3)
          3'b000: ctrl_o.alu_operator = decoder_pkg::ALU_EQ;
          3'b001: ctrl_o.alu_operator = decoder_pkg::ALU_NE;
          3'b100: ctrl_o.alu_operator = decoder_pkg::ALU_LTS;
          3'b101: ctrl_o.alu_operator = decoder_pkg::ALU_GES;
          3'b110: ctrl_o.alu_operator = decoder_pkg::ALU_LTU;
          3'b111: ctrl_o.alu_operator = decoder_pkg::ALU_GEU;
          default: begin
            ctrl_o.illegal    = 1'b1;
            ctrl_o.jump_in_id = decoder_pkg::BRANCH_NONE;  // never take it
          end
        endcase
      end

      default: hit_o = 1'b0;                   // not a flow opcode
    endcase
  end

endmodule

/* logic/mem_decoder.sv */
`timescale 1ns/1ns

module mem_decoder (
  input  decoder_pkg::insn_u insn_i,
  output logic               hit_o,
  output decoder_pkg::ctrl_t ctrl_o
);

  logic [2:0] funct3;
  logic       bad_access;                      // reserved size or rv64 only form

  assign funct3 = insn_i.r_fmt.funct3;

  always_comb begin
    hit_o      = 1'b1;
    bad_access = (funct3[1:0] == 2'b11);       // no double word on rv32
    ctrl_o     = decoder_pkg::CTRL_IDLE;

    // address is rs1 + imm for both directions
    ctrl_o.alu_operator = decoder_pkg::ALU_ADD;
    ctrl_o.op_b_sel     = decoder_pkg::OP_B_IMM;
    ctrl_o.rega_used    = 1'b1;

    case (funct3[1:0])
      2'b00:   ctrl_o.data_type = decoder_pkg::DT_BYTE;
      2'b01:   ctrl_o.data_type = decoder_pkg::DT_HALF;
      default: ctrl_o.data_type = decoder_pkg::DT_WORD;
    endcase

    case (insn_i.r_fmt.opcode)
      decoder_pkg::OPC_LOAD: begin
        ctrl_o.imm_sel        = decoder_pkg::IMM_I;
        ctrl_o.data_req       = 1'b1;
        ctrl_o.regfile_mem_we = 1'b1;
        ctrl_o.data_sign_ext  = ~funct3[2];    // lbu / lhu zero extend
        if (funct3 == 3'b110) bad_access = 1'b1;  // lwu
      end
      decoder_pkg::OPC_STORE: begin
        ctrl_o.imm_sel   = decoder_pkg::IMM_S;
        ctrl_o.regb_used = 1'b1;               // store data
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        if (funct3[2]) bad_access = 1'b1;
      end
      default: begin
        hit_o      = 1'b0;
        bad_access = 1'b0;
      end
    endcase

    if (bad_access) begin                      // kill the bus request
      ctrl_o.illegal        = 1'b1;
      ctrl_o.data_req       = 1'b0;
      ctrl_o.data_we        = 1'b0;
      ctrl_o.regfile_mem_we = 1'b0;
      ctrl_o.regfile_alu_we = 1'b0;
    end
  end

endmodule

/* logic/alu_decoder.sv */
`timescale 1ns/1ns

module alu_decoder (
  input  decoder_pkg::insn_u insn_i,
  output logic               hit_o,
  output decoder_pkg::ctrl_t ctrl_o
);

  logic [2:0] funct3;
  logic [6:0] shamt_hi;                        // imm12[11:5] of a shift immediate

  assign funct3   = insn_i.i_fmt.funct3;
  assign shamt_hi = insn_i.i_fmt.imm12[11:5];

  always_comb begin
    hit_o  = 1'b1;
    ctrl_o = decoder_pkg::CTRL_IDLE;
    ctrl_o.regfile_alu_we = 1'b1;              // all legal ops write rd

    case (insn_i.r_fmt.opcode)
      decoder_pkg::OPC_LUI, decoder_pkg::OPC_AUIPC: begin
        ctrl_o.op_a_sel     = (insn_i.r_fmt.opcode == decoder_pkg::OPC_LUI) ?
                              decoder_pkg::OP_A_ZERO : decoder_pkg::OP_A_CURRPC;
        ctrl_o.op_b_sel     = decoder_pkg::OP_B_IMM;
        ctrl_o.imm_sel      = decoder_pkg::IMM_U;
        ctrl_o.alu_operator = decoder_pkg::ALU_ADD;
      end

      ////////////////////////////////////////
      // register - immediate
      ////////////////////////////////////////
      decoder_pkg::OPC_OPIMM: begin
        ctrl_o.op_b_sel  = decoder_pkg::OP_B_IMM;
        ctrl_o.imm_sel   = decoder_pkg::IMM_I;
        ctrl_o.rega_used = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_operator = decoder_pkg::ALU_ADD;   // addi
          3'b010: ctrl_o.alu_operator = decoder_pkg::ALU_SLTS;  // slti
          3'b011: ctrl_o.alu_operator = decoder_pkg::ALU_SLTU;  // sltiu
          3'b100: ctrl_o.alu_operator = decoder_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_operator = decoder_pkg::ALU_OR;
          3'b111: ctrl_o.alu_operator = decoder_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_operator = decoder_pkg::ALU_SLL;
            ctrl_o.illegal      = (shamt_hi != 7'b000_0000);
          end
          default: begin                       // 101, srli or srai
            ctrl_o.alu_operator = shamt_hi[5] ? decoder_pkg::ALU_SRA : decoder_pkg::ALU_SRL;
            ctrl_o.illegal      = (shamt_hi != 7'b000_0000) && (shamt_hi != 7'b010_0000);
          end
        endcase
      end

      ////////////////////////////////////////
      // register - register
      ////////////////////////////////////////
      decoder_pkg::OPC_OP: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;
        case ({insn_i.r_fmt.funct7, funct3})
          {7'b000_0000, 3'b000}: ctrl_o.alu_operator = decoder_pkg::ALU_ADD;
          {7'b010_0000, 3'b000}: ctrl_o.alu_operator = decoder_pkg::ALU_SUB;
          {7'b000_0000, 3'b001}: ctrl_o.alu_operator = decoder_pkg::ALU_SLL;
          {7'b000_0000, 3'b010}: ctrl_o.alu_operator = decoder_pkg::ALU_SLTS;
          {7'b000_0000, 3'b011}: ctrl_o.alu_operator = decoder_pkg::ALU_SLTU;
          {7'b000_0000, 3'b100}: ctrl_o.alu_operator = decoder_pkg::ALU_XOR;
          {7'b000_0000, 3'b101}: ctrl_o.alu_operator = decoder_pkg::ALU_SRL;
          {7'b010_0000, 3'b101}: ctrl_o.alu_operator = decoder_pkg::ALU_SRA;
          {7'b000_0000, 3'b110}: ctrl_o.alu_operator = decoder_pkg::ALU_OR;
          {7'b000_0000, 3'b111}: ctrl_o.alu_operator = decoder_pkg::ALU_AND;
          {7'b000_0001, 3'b000}: ctrl_o.mult_en      = 1'b1;  // mul, low word only
          default:               ctrl_o.illegal      = 1'b1;
        endcase
      end

      default: begin
        hit_o                 = 1'b0;
        ctrl_o.regfile_alu_we = 1'b0;
      end
    endcase

    if (ctrl_o.illegal) begin                  // no writeback on bad encodings
      ctrl_o.regfile_alu_we = 1'b0;
      ctrl_o.mult_en        = 1'b0;
    end
  end

  // multiplier result always lands in rd through the alu port
  a_mul_writes_rd : assert property (@(insn_i) ctrl_o.mult_en |-> ctrl_o.regfile_alu_we);

endmodule

/* logic/system_decoder.sv */
`timescale 1ns/1ns

module system_decoder (
  input  decoder_pkg::insn_u insn_i,
  output logic               hit_o,
  output decoder_pkg::ctrl_t ctrl_o
);

  logic [2:0] funct3;
  logic       no_regs;                         // rs1 and rd both x0

  assign funct3  = insn_i.i_fmt.funct3;
  assign no_regs = (insn_i.i_fmt.rs1 == 5'd0) && (insn_i.i_fmt.rd == 5'd0);

  always_comb begin
    hit_o  = (insn_i.i_fmt.opcode == decoder_pkg::OPC_SYSTEM);
    ctrl_o = decoder_pkg::CTRL_IDLE;

    if (funct3 == 3'b000) begin
      // priv ops, only the exact words are legal
      case ({no_regs, insn_i.i_fmt.imm12})
        {1'b1, 12'h000}: ctrl_o.ecall      = 1'b1;
        {1'b1, 12'h001}: ctrl_o.trap       = 1'b1;  // ebreak
        {1'b1, 12'h100}: ctrl_o.eret       = 1'b1;
        {1'b1, 12'h102}: ctrl_o.pipe_flush = 1'b1;  // wfi drains the pipe
        default:         ctrl_o.illegal    = 1'b1;
      endcase
    end else begin
      ctrl_o.csr_access     = 1'b1;
      ctrl_o.regfile_alu_we = 1'b1;            // old csr value to rd
      ctrl_o.op_b_sel       = decoder_pkg::OP_B_IMM;
      ctrl_o.imm_sel        = decoder_pkg::IMM_I;  // csr address in imm12
      if (funct3[2]) begin
        ctrl_o.op_a_sel  = decoder_pkg::OP_A_ZIMM;  // rs1 field as uimm
      end else begin
        ctrl_o.op_a_sel  = decoder_pkg::OP_A_REGA;
        ctrl_o.rega_used = 1'b1;
      end
      case (funct3[1:0])
        2'b01:   ctrl_o.csr_op = decoder_pkg::CSR_WRITE;
        2'b10:   ctrl_o.csr_op = decoder_pkg::CSR_SET;
        2'b11:   ctrl_o.csr_op = decoder_pkg::CSR_CLEAR;
        default: begin
          ctrl_o.illegal        = 1'b1;
          ctrl_o.csr_access     = 1'b0;
          ctrl_o.regfile_alu_we = 1'b0;
        end
      endcase
    end
  end

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/1ns

module id_ex_reg (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 deassert_we_i,  // stall level from controller
  input  decoder_pkg::ctrl_t   ctrl_i,
  output decoder_pkg::ctrl_t   ctrl_o,
  output decoder_pkg::branch_e jump_in_dec_o
);

  decoder_pkg::ctrl_t ctrl_gated;

  ////////////////////////////////////////
  // stall gating
  ////////////////////////////////////////
  always_comb begin
    ctrl_gated = ctrl_i;
    if (deassert_we_i) begin                   // squash side effects only
      ctrl_gated.regfile_alu_we = 1'b0;
      ctrl_gated.regfile_mem_we = 1'b0;
      ctrl_gated.data_req       = 1'b0;
      ctrl_gated.mult_en        = 1'b0;
      ctrl_gated.csr_op         = decoder_pkg::CSR_NONE;
      ctrl_gated.jump_in_id     = decoder_pkg::BRANCH_NONE;
      ctrl_gated.trap           = 1'b0;
      ctrl_gated.eret           = 1'b0;
      ctrl_gated.pipe_flush     = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_o        <= decoder_pkg::CTRL_IDLE;
      jump_in_dec_o <= decoder_pkg::BRANCH_NONE;
    end else begin
      ctrl_o        <= ctrl_gated;
      jump_in_dec_o <= ctrl_i.jump_in_id;      // ungated, for the prefetcher
    end
  end

  // a store that was not stalled must reach the bus
  a_store_has_req : assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_o.data_we && !$past(deassert_we_i) |-> ctrl_o.data_req);

endmodule

/* logic/riscv_decoder.sv */
`timescale 1ns/1ns

module riscv_decoder (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  decoder_pkg::insn_u   instr_rdata_i,  // from the if/id register
  input  logic                 deassert_we_i,
  output decoder_pkg::ctrl_t   ctrl_o,
  output decoder_pkg::branch_e jump_in_dec_o
);

  logic [3:0]         hit;                     // flow, mem, alu, system
  decoder_pkg::ctrl_t flow_ctrl, mem_ctrl, alu_ctrl, sys_ctrl;
  decoder_pkg::ctrl_t ctrl_merged;

  if ($bits(decoder_pkg::insn_u) != decoder_pkg::INSN_W) begin : g_insn_w_chk
    $error("instruction union does not match INSN_W");
  end

  flow_decoder   i_flow_decoder   (.insn_i(instr_rdata_i), .hit_o(hit[3]), .ctrl_o(flow_ctrl));
  mem_decoder    i_mem_decoder    (.insn_i(instr_rdata_i), .hit_o(hit[2]), .ctrl_o(mem_ctrl));
  alu_decoder    i_alu_decoder    (.insn_i(instr_rdata_i), .hit_o(hit[1]), .ctrl_o(alu_ctrl));
  system_decoder i_system_decoder (.insn_i(instr_rdata_i), .hit_o(hit[0]), .ctrl_o(sys_ctrl));

  ////////////////////////////////////////
  // merge by hit flag
  ////////////////////////////////////////
  always_comb begin
    case (hit)
      4'b1000: ctrl_merged = flow_ctrl;
      4'b0100: ctrl_merged = mem_ctrl;
      4'b0010: ctrl_merged = alu_ctrl;
      4'b0001: ctrl_merged = sys_ctrl;
      default: begin                           // unknown opcode
        ctrl_merged         = decoder_pkg::CTRL_IDLE;
        ctrl_merged.illegal = 1'b1;
      end
    endcase
  end

  id_ex_reg i_id_ex_reg (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .deassert_we_i (deassert_we_i),
    .ctrl_i        (ctrl_merged),
    .ctrl_o        (ctrl_o),
    .jump_in_dec_o (jump_in_dec_o)
  );

  // opcode classes never overlap across the decoders
  a_hit_onehot : assert property (@(posedge clk) disable iff (!arst_n_i) $onehot0(hit));

endmodule

/* tests/decoder_checker.sv */
`timescale 1ns/1ns

module decoder_checker (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  decoder_pkg::ctrl_t   ctrl_i,          // dut id/ex register
  input  decoder_pkg::branch_e jump_in_dec_i,
  input  logic                 exp_vld_i,       // a vector was driven last falling edge
  input  logic [7:0]           exp_id_i,
  input  decoder_pkg::ctrl_t   exp_ctrl_i,
  input  decoder_pkg::branch_e exp_jump_dec_i,
  output int                   n_checks_o,
  output int                   n_errors_o
);

  int                   checks = 0;
  int                   errors = 0;
  logic                 in_reset_q = 1'b0;     // reset seen at the last rising edge
  logic                 exp_vld_q = 1'b0;
  logic [7:0]           exp_id_q = 8'h00;
  decoder_pkg::ctrl_t   exp_ctrl_q;
  decoder_pkg::branch_e exp_jump_dec_q;

  assign n_checks_o = checks;
  assign n_errors_o = errors;

  // group nibble of the id picks the name
  function automatic string test_name(input logic [7:0] id);
    string grp;
    case (id[7:4])
      4'h2:    grp = "alu";
      4'h3:    grp = "mem";
      4'h4:    grp = "flow";
      4'h5:    grp = "system";
      4'h6:    grp = "stall";
      default: grp = "vector";
    endcase
    return $sformatf("%s_%0d", grp, id[3:0]);
  endfunction

  // everything low after reset except the idle operator
  function automatic decoder_pkg::ctrl_t reset_expect();
    decoder_pkg::ctrl_t c;
    c              = '0;
    c.alu_operator = decoder_pkg::ALU_SLTU;
    return c;
  endfunction

  task automatic check_field(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error: %s %s expected %0h actual %0h", test, field, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic compare_ctrl(input string test, input decoder_pkg::ctrl_t exp_c,
                              input decoder_pkg::branch_e exp_jd);
    check_field(test, "alu_operator", 32'(exp_c.alu_operator), 32'(ctrl_i.alu_operator));
    check_field(test, "illegal", 32'(exp_c.illegal), 32'(ctrl_i.illegal));
    check_field(test, "regfile_alu_we", 32'(exp_c.regfile_alu_we), 32'(ctrl_i.regfile_alu_we));
    check_field(test, "regfile_mem_we", 32'(exp_c.regfile_mem_we), 32'(ctrl_i.regfile_mem_we));
    check_field(test, "data_req", 32'(exp_c.data_req), 32'(ctrl_i.data_req));
    check_field(test, "data_we", 32'(exp_c.data_we), 32'(ctrl_i.data_we));
    check_field(test, "data_type", 32'(exp_c.data_type), 32'(ctrl_i.data_type));
    check_field(test, "csr_op", 32'(exp_c.csr_op), 32'(ctrl_i.csr_op));
    check_field(test, "jump_in_id", 32'(exp_c.jump_in_id), 32'(ctrl_i.jump_in_id));
    check_field(test, "trap_flags",                // ecall, ebreak, eret, wfi
                32'({exp_c.ecall, exp_c.trap, exp_c.eret, exp_c.pipe_flush}),
                32'({ctrl_i.ecall, ctrl_i.trap, ctrl_i.eret, ctrl_i.pipe_flush}));
    check_field(test, "mult_en", 32'(exp_c.mult_en), 32'(ctrl_i.mult_en));
    check_field(test, "data_sign_ext", 32'(exp_c.data_sign_ext), 32'(ctrl_i.data_sign_ext));
    check_field(test, "jump_in_dec", 32'(exp_jd), 32'(jump_in_dec_i));
  endtask

  ////////////////////////////////////////
  // capture on one edge and compare on the next
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (!arst_n_i || in_reset_q) begin           // still the reset value here
      compare_ctrl("reset", reset_expect(), decoder_pkg::BRANCH_NONE);
    end
    if (exp_vld_q) begin                         // dut captured this one last edge
      compare_ctrl(test_name(exp_id_q), exp_ctrl_q, exp_jump_dec_q);
      checks++;
    end
    in_reset_q     <= !arst_n_i;
    exp_vld_q      <= exp_vld_i;
    exp_id_q       <= exp_id_i;
    exp_ctrl_q     <= exp_ctrl_i;
    exp_jump_dec_q <= exp_jump_dec_i;
  end

endmodule

/* tests/tb_riscv_decoder.sv */
`timescale 1ns/1ns

module tb_riscv_decoder;

  localparam int MAX_VEC  = 64;
  localparam int N_FLD    = 16;                // words per vector in the stim file
  localparam int CLK_HALF = 20;

  logic                 clk = 1'b1;            // first edge is a falling one
  logic                 arst_n_i;
  logic                 deassert_we_i;
  decoder_pkg::insn_u   instr_rdata;
  decoder_pkg::ctrl_t   ctrl;
  decoder_pkg::branch_e jump_in_dec;

  logic                 exp_vld;
  logic [7:0]           exp_id;
  decoder_pkg::ctrl_t   exp_ctrl;
  decoder_pkg::branch_e exp_jump_dec;
  int                   n_checks;
  int                   n_errors;
  int                   tb_errors;
  int                   n_vec;
  logic                 loaded;
  logic [31:0]          stim_mem [0:MAX_VEC*N_FLD-1];

  always #CLK_HALF clk = ~clk;                  // 40 ns period

  riscv_decoder i_riscv_decoder (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_rdata_i (instr_rdata),
    .deassert_we_i (deassert_we_i),
    .ctrl_o        (ctrl),
    .jump_in_dec_o (jump_in_dec)
  );

  decoder_checker i_decoder_checker (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .ctrl_i         (ctrl),
    .jump_in_dec_i  (jump_in_dec),
    .exp_vld_i      (exp_vld),
    .exp_id_i       (exp_id),
    .exp_ctrl_i     (exp_ctrl),
    .exp_jump_dec_i (exp_jump_dec),
    .n_checks_o     (n_checks),
    .n_errors_o     (n_errors)
  );

  // fields not in the file keep their idle value
  task automatic drive_vector(input int v);
    int b;
    b = v * N_FLD;
    exp_id        = stim_mem[b][7:0];
    instr_rdata   = stim_mem[b+1];
    deassert_we_i = stim_mem[b+2][0];
    exp_ctrl                = decoder_pkg::CTRL_IDLE;
    exp_ctrl.alu_operator   = decoder_pkg::alu_op_e'(stim_mem[b+3][4:0]);
    exp_ctrl.illegal        = stim_mem[b+4][0];
    exp_ctrl.regfile_alu_we = stim_mem[b+5][0];
    exp_ctrl.regfile_mem_we = stim_mem[b+6][0];
    exp_ctrl.data_req       = stim_mem[b+7][0];
    exp_ctrl.data_we        = stim_mem[b+8][0];
    exp_ctrl.data_type      = decoder_pkg::data_type_e'(stim_mem[b+9][1:0]);
    exp_ctrl.csr_op         = decoder_pkg::csr_op_e'(stim_mem[b+10][1:0]);
    exp_ctrl.jump_in_id     = decoder_pkg::branch_e'(stim_mem[b+11][1:0]);
    {exp_ctrl.ecall, exp_ctrl.trap, exp_ctrl.eret, exp_ctrl.pipe_flush} = stim_mem[b+12][3:0];
    exp_ctrl.mult_en        = stim_mem[b+13][0];
    exp_ctrl.data_sign_ext  = stim_mem[b+14][0];
    exp_jump_dec            = decoder_pkg::branch_e'(stim_mem[b+15][1:0]);
    exp_vld                 = 1'b1;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    arst_n_i      = 1'b1;
    deassert_we_i = 1'b0;
    instr_rdata   = '0;
    exp_vld       = 1'b0;
    exp_id        = 8'h00;
    exp_ctrl      = decoder_pkg::CTRL_IDLE;
    exp_jump_dec  = decoder_pkg::BRANCH_NONE;
    tb_errors     = 0;
    loaded        = 1'b0;
    for (int i = 0; i < MAX_VEC * N_FLD; i++) begin
      stim_mem[i] = 32'hfff0_0000 | 32'(i);    // id word fff... marks the end
    end
    $readmemh("tests/decoder_stim.txt", stim_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && stim_mem[n_vec * N_FLD][31:20] != 12'hfff) n_vec++;
    loaded = 1'b1;
    if (n_vec == 0) begin
      $display("the stimulus file tests/decoder_stim.txt holds no vectors");
      tb_errors++;
    end

    @(negedge clk);
    arst_n_i = 1'b0;
    repeat (3) @(negedge clk);
    arst_n_i = 1'b1;
    for (int v = 0; v < n_vec; v++) begin
      drive_vector(v);
      @(negedge clk);
    end
    exp_vld = 1'b0;

    wait (n_checks == n_vec);                  // checker lags two edges
    @(negedge clk);
    $display("vectors %0d, checked %0d, mismatches %0d, other failures %0d",
             n_vec, n_checks, n_errors, tb_errors);
    if (n_errors == 0 && tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, vector count plus 10 cycles
  initial begin
    wait (loaded);
    #((n_vec + 10) * 2 * CLK_HALF);
    $display("Timeout: the checker did not compare every vector in time");
    $display("Errors found");
    $finish;
  end

endmodule

/* tests/decoder_stim.txt */
// id insn stall alu_op illegal alu_we mem_we req we dtype csr jump flags(ecall,ebrk,eret,wfi)
// then mult_en sign_ext jump_in_dec, all hex
21 003100b3 0 0 0 1 0 0 0 0 0 0 0 0 0 0  // add
22 403100b3 0 1 0 1 0 0 0 0 0 0 0 0 0 0  // sub
23 403150b3 0 7 0 1 0 0 0 0 0 0 0 0 0 0  // sra
24 003130b3 0 9 0 1 0 0 0 0 0 0 0 0 0 0  // sltu
25 123450b7 0 0 0 1 0 0 0 0 0 0 0 0 0 0  // lui
26 00f14093 0 2 0 1 0 0 0 0 0 0 0 0 0 0  // xori
27 023100b3 0 9 0 1 0 0 0 0 0 0 0 1 0 0  // mul
28 083100b3 0 9 1 0 0 0 0 0 0 0 0 0 0 0  // op funct7 0000100
31 00410083 0 0 0 0 1 1 0 2 0 0 0 0 1 0  // lb
32 00415083 0 0 0 0 1 1 0 1 0 0 0 0 0 0  // lhu
33 00412083 0 0 0 0 1 1 0 0 0 0 0 0 1 0  // lw
34 00310223 0 0 0 0 0 1 1 2 0 0 0 0 0 0  // sb
35 00312223 0 0 0 0 0 1 1 0 0 0 0 0 0 0  // sw
36 00413083 0 0 1 0 0 0 0 0 0 0 0 0 1 0  // load funct3 011
41 008000ef 0 0 0 1 0 0 0 0 0 1 0 0 0 1  // jal
42 000100e7 0 0 0 1 0 0 0 0 0 2 0 0 0 2  // jalr
43 00310463 0 a 0 0 0 0 0 0 0 3 0 0 0 3  // beq
44 00317463 0 f 0 0 0 0 0 0 0 3 0 0 0 3  // bgeu
45 00312463 0 9 1 0 0 0 0 0 0 0 0 0 0 0  // branch funct3 010
51 00000073 0 9 0 0 0 0 0 0 0 0 8 0 0 0  // ecall
52 00100073 0 9 0 0 0 0 0 0 0 0 4 0 0 0  // ebreak
53 10000073 0 9 0 0 0 0 0 0 0 0 2 0 0 0  // eret
54 10200073 0 9 0 0 0 0 0 0 0 0 1 0 0 0  // wfi
55 300120f3 0 9 0 1 0 0 0 0 2 0 0 0 0 0  // csrrs
56 300140f3 0 9 1 0 0 0 0 0 0 0 0 0 0 0  // system funct3 100
57 0000000b 0 9 1 0 0 0 0 0 0 0 0 0 0 0  // unknown opcode
61 00412083 1 0 0 0 0 0 0 0 0 0 0 0 1 0  // lw stalled
62 008000ef 1 0 0 0 0 0 0 0 0 0 0 0 0 1  // jal stalled
63 300120f3 1 9 0 0 0 0 0 0 0 0 0 0 0 0  // csrrs stalled
64 003100b3 0 0 0 1 0 0 0 0 0 0 0 0 0 0  // add after stall

/* list.f */
logic/decoder_pkg.sv
logic/flow_decoder.sv
logic/mem_decoder.sv
logic/alu_decoder.sv
logic/system_decoder.sv
logic/id_ex_reg.sv
logic/riscv_decoder.sv
tests/decoder_checker.sv
tests/tb_riscv_decoder.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_riscv_decoder
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "No errors" > /dev/null

clean:
	rm -rf obj_dir
